// ==== hdl/parking_pkg.sv ====
// Sizes, codes and packed types shared by the parking tower RTL and its testbench
// Referenced by scoped names, e.g. parking_pkg::request_t
package parking_pkg;

	// Tower geometry and widths
	localparam int NUM_FLOORS = 7;
	localparam int PLATE_W = 16;
	localparam int FEE_W = 8;
	localparam int FEE_MAX = 255;
	localparam int QUEUE_DEPTH = 8;
	localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);

	// Plate prefix codes in the top nibble
	localparam logic [3:0] DISABLED_PREFIX = 4'h9;
	localparam logic [3:0] HYBRID_PREFIX = 4'h8;

	// Fee added per cycle of occupancy
	localparam logic [1:0] RATE_STANDARD = 2'd2;
	localparam logic [1:0] RATE_HYBRID = 2'd1;
	localparam logic [1:0] RATE_DISABLED = 2'd0;

	// Zero plate marks an empty slot
	typedef logic [PLATE_W-1:0] plate_t;
	typedef logic [2:0] floor_t;
	typedef logic [FEE_W-1:0] fee_t;
	// Wide enough for all eight odd-floor places
	typedef logic [3:0] count_t;

	typedef enum logic {
		REQ_PARK,
		REQ_RETRIEVE
	} req_kind_t;

	typedef struct packed {
		req_kind_t kind;
		plate_t plate;
	} request_t;

	// Place 0 is left, place 1 is right
	typedef struct packed {
		floor_t floor;
		logic place;
	} slot_addr_t;

	typedef struct packed {
		logic strobe;
		slot_addr_t addr;
		plate_t plate;
	} slot_write_t;

	// Outer index is floor minus one
	typedef plate_t [NUM_FLOORS-1:0][1:0] slot_table_t;

endpackage

// ==== hdl/request_queue.sv ====
// Circular FIFO of pending park and retrieve requests in arrival order
// Pushes are dropped while full; the lift pops the head entry
`timescale 1ns/1ps

module request_queue (
	input logic clock,
	input logic reset,
	input logic push,
	input parking_pkg::request_t push_req,
	input logic pop,
	output parking_pkg::request_t head,
	output logic head_valid,
	output logic full
);

	parking_pkg::request_t entries [parking_pkg::QUEUE_DEPTH];
	logic [parking_pkg::QUEUE_PTR_W-1:0] rd_ptr;
	logic [parking_pkg::QUEUE_PTR_W-1:0] wr_ptr;
	logic [parking_pkg::QUEUE_PTR_W:0] count;
	logic do_push;
	logic do_pop;

	function automatic logic [parking_pkg::QUEUE_PTR_W-1:0] ptr_next(
		input logic [parking_pkg::QUEUE_PTR_W-1:0] ptr
	);
		if (ptr == parking_pkg::QUEUE_PTR_W'(parking_pkg::QUEUE_DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign full = (count == (parking_pkg::QUEUE_PTR_W + 1)'(parking_pkg::QUEUE_DEPTH));
	assign head_valid = (count != '0);
	assign head = entries[rd_ptr];

	// A full queue still refuses the push even if the head leaves this cycle
	assign do_push = push && !full;
	assign do_pop = pop && head_valid;

	always_ff @(posedge clock) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (do_push) begin
			entries[wr_ptr] <= push_req;
		end
	end

endmodule

// ==== hdl/slot_search.sv ====
// Combinational slot lookup for the head request
// Finds a free place for the plate's class and the place already holding the plate
`timescale 1ns/1ps

module slot_search (
	input parking_pkg::slot_table_t slot_table,
	input parking_pkg::plate_t plate,
	output logic free_found,
	output parking_pkg::slot_addr_t free_addr,
	output logic hit_found,
	output parking_pkg::slot_addr_t hit_addr
);

	logic is_sedan;

	// Plate bit 0 clear means sedan
	assign is_sedan = !plate[0];

	// Scans run top down so the last match is the lowest floor and the left place
	always_comb begin
		free_found = 1'b0;
		free_addr = '0;
		// Odd floors serve SUVs and overflowing sedans
		for (int f = parking_pkg::NUM_FLOORS; f >= 1; f--) begin
			for (int p = 1; p >= 0; p--) begin
				if ((f % 2 == 1) && (slot_table[f-1][p] == '0)) begin
					free_found = 1'b1;
					free_addr.floor = parking_pkg::floor_t'(f);
					free_addr.place = 1'(p);
				end
			end
		end
		// Any free even floor overrides the odd result for a sedan
		for (int f = parking_pkg::NUM_FLOORS; f >= 1; f--) begin
			for (int p = 1; p >= 0; p--) begin
				if (is_sedan && (f % 2 == 0) && (slot_table[f-1][p] == '0)) begin
					free_found = 1'b1;
					free_addr.floor = parking_pkg::floor_t'(f);
					free_addr.place = 1'(p);
				end
			end
		end
	end

	always_comb begin
		hit_found = 1'b0;
		hit_addr = '0;
		for (int f = 1; f <= parking_pkg::NUM_FLOORS; f++) begin
			for (int p = 0; p < 2; p++) begin
				// Zero plate would match every empty place
				if ((plate != '0) && (slot_table[f-1][p] == plate)) begin
					hit_found = 1'b1;
					hit_addr.floor = parking_pkg::floor_t'(f);
					hit_addr.place = 1'(p);
				end
			end
		end
	end

endmodule

// ==== hdl/slot_map.sv ====
// Registered plate table of the tower, written only through the lift's slot write
// Also counts the empty places on sedan (even) and SUV (odd) floors
`timescale 1ns/1ps

module slot_map (
	input logic clock,
	input logic reset,
	input parking_pkg::slot_write_t slot_wr,
	output parking_pkg::slot_table_t slot_table,
	output parking_pkg::count_t free_sedan,
	output parking_pkg::count_t free_suv
);

	// Store writes the plate, pickup writes zero
	always_ff @(posedge clock) begin
		if (reset) begin
			slot_table <= '0;
		end else if (slot_wr.strobe) begin
			slot_table[slot_wr.addr.floor - 1'b1][slot_wr.addr.place] <= slot_wr.plate;
		end
	end

	always_comb begin
		free_sedan = '0;
		free_suv = '0;
		for (int f = 1; f <= parking_pkg::NUM_FLOORS; f++) begin
			for (int p = 0; p < 2; p++) begin
				if (slot_table[f-1][p] == '0) begin
					if (f % 2 == 0) begin
						free_sedan = free_sedan + 1'b1;
					end else begin
						free_suv = free_suv + 1'b1;
					end
				end
			end
		end
	end

endmodule

// ==== hdl/fee_meters.sv ====
// One saturating fee meter per slot, started by a store and cleared by a pickup
// Readout of the addressed slot includes the current cycle's rate
`timescale 1ns/1ps

module fee_meters (
	input logic clock,
	input logic reset,
	input parking_pkg::slot_write_t slot_wr,
	input parking_pkg::slot_addr_t fee_addr,
	output parking_pkg::fee_t fee_value
);

	parking_pkg::fee_t count [parking_pkg::NUM_FLOORS][2];
	parking_pkg::fee_t count_next [parking_pkg::NUM_FLOORS][2];
	logic occupied [parking_pkg::NUM_FLOORS][2];
	logic [1:0] rate [parking_pkg::NUM_FLOORS][2];

	function automatic logic [1:0] rate_of(input parking_pkg::plate_t plate);
		logic [3:0] prefix;
		prefix = plate[parking_pkg::PLATE_W-1 -: 4];
		if (prefix == parking_pkg::DISABLED_PREFIX) begin
			return parking_pkg::RATE_DISABLED;
		end
		if (prefix == parking_pkg::HYBRID_PREFIX) begin
			return parking_pkg::RATE_HYBRID;
		end
		return parking_pkg::RATE_STANDARD;
	endfunction

	function automatic parking_pkg::fee_t sat_add(
		input parking_pkg::fee_t value,
		input logic [1:0] step
	);
		logic [parking_pkg::FEE_W:0] sum;
		sum = {1'b0, value} + step;
		if (sum > parking_pkg::FEE_MAX) begin
			return parking_pkg::fee_t'(parking_pkg::FEE_MAX);
		end
		return sum[parking_pkg::FEE_W-1:0];
	endfunction

	always_comb begin
		for (int f = 0; f < parking_pkg::NUM_FLOORS; f++) begin
			for (int p = 0; p < 2; p++) begin
				count_next[f][p] = occupied[f][p] ? sat_add(count[f][p], rate[f][p]) : '0;
			end
		end
	end

	assign fee_value = count_next[fee_addr.floor - 1'b1][fee_addr.place];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int f = 0; f < parking_pkg::NUM_FLOORS; f++) begin
				for (int p = 0; p < 2; p++) begin
					count[f][p] <= '0;
					occupied[f][p] <= 1'b0;
				end
			end
		end else begin
			for (int f = 0; f < parking_pkg::NUM_FLOORS; f++) begin
				for (int p = 0; p < 2; p++) begin
					if (slot_wr.strobe && (slot_wr.addr.floor == parking_pkg::floor_t'(f + 1))
							&& (slot_wr.addr.place == 1'(p))) begin
						// Store starts a fresh meter, pickup stops it
						count[f][p] <= '0;
						occupied[f][p] <= (slot_wr.plate != '0);
					end else begin
						count[f][p] <= count_next[f][p];
					end
				end
			end
		end
	end

	// Rate is latched with the plate class at store
	always_ff @(posedge clock) begin
		for (int f = 0; f < parking_pkg::NUM_FLOORS; f++) begin
			for (int p = 0; p < 2; p++) begin
				if (slot_wr.strobe && (slot_wr.plate != '0)
						&& (slot_wr.addr.floor == parking_pkg::floor_t'(f + 1))
						&& (slot_wr.addr.place == 1'(p))) begin
					rate[f][p] <= rate_of(slot_wr.plate);
				end
			end
		end
	end

endmodule

// ==== hdl/lift_controller.sv ====
// Lift FSM: takes the head request in idle, climbs to the slot, stores or picks up,
// then returns to floor 0 and reports the outcome
`timescale 1ns/1ps

module lift_controller (
	input logic clock,
	input logic reset,
	input parking_pkg::request_t head,
	input logic head_valid,
	output logic pop,
	input logic free_found,
	input logic hit_found,
	input parking_pkg::slot_addr_t free_addr,
	input parking_pkg::slot_addr_t hit_addr,
	output parking_pkg::slot_write_t slot_wr,
	output parking_pkg::slot_addr_t fee_addr,
	input parking_pkg::fee_t fee_value,
	output parking_pkg::floor_t current_floor,
	output parking_pkg::plate_t carried_plate,
	output logic park_done,
	output parking_pkg::slot_addr_t park_addr,
	output logic retrieve_done,
	output parking_pkg::fee_t fee,
	output logic reject
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_RISE,
		S_STORE,
		S_PICKUP,
		S_DESCEND
	} lift_state_t;

	lift_state_t state;
	parking_pkg::slot_addr_t target;
	parking_pkg::plate_t job_plate;
	parking_pkg::req_kind_t job_kind;
	parking_pkg::floor_t floor_up;
	logic head_ok;

	// Head is taken only while idle; unservable requests are dropped with reject
	assign pop = head_valid && (state == S_IDLE);
	assign head_ok = (head.kind == parking_pkg::REQ_PARK) ? free_found : hit_found;
	assign reject = pop && !head_ok;

	assign floor_up = current_floor + 1'b1;

	assign slot_wr.strobe = (state == S_STORE) || (state == S_PICKUP);
	assign slot_wr.addr = target;
	assign slot_wr.plate = (state == S_STORE) ? carried_plate : '0;

	assign fee_addr = target;
	assign park_addr = target;
	assign park_done = (state == S_STORE);
	assign retrieve_done = (state == S_DESCEND) && (job_kind == parking_pkg::REQ_RETRIEVE)
		&& (current_floor == parking_pkg::floor_t'(1));

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= S_IDLE;
			current_floor <= '0;
			carried_plate <= '0;
			fee <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (pop && head_ok) begin
						state <= S_RISE;
						// A car to park is loaded at the entry level
						if (head.kind == parking_pkg::REQ_PARK) begin
							carried_plate <= head.plate;
						end
					end
				end
				S_RISE: begin
					current_floor <= floor_up;
					if (floor_up == target.floor) begin
						state <= (job_kind == parking_pkg::REQ_PARK) ? S_STORE : S_PICKUP;
					end
				end
				S_STORE: begin
					carried_plate <= '0;
					state <= S_DESCEND;
				end
				S_PICKUP: begin
					// Meter still holds its count in this cycle
					carried_plate <= job_plate;
					fee <= fee_value;
					state <= S_DESCEND;
				end
				S_DESCEND: begin
					current_floor <= current_floor - 1'b1;
					if (current_floor == parking_pkg::floor_t'(1)) begin
						carried_plate <= '0;
						state <= S_IDLE;
					end
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (pop) begin
			target <= (head.kind == parking_pkg::REQ_PARK) ? free_addr : hit_addr;
			job_plate <= head.plate;
			job_kind <= head.kind;
		end
	end

endmodule

// ==== hdl/parking_tower.sv ====
// Top level of the parking tower controller
// Connects the request FIFO, slot search, slot map, fee meters and lift FSM
`timescale 1ns/1ps

module parking_tower (
	input logic clock,
	input logic reset,
	input logic req_valid,
	input parking_pkg::request_t req,
	output logic queue_full,
	output logic park_done,
	output logic retrieve_done,
	output logic reject,
	output parking_pkg::slot_addr_t park_addr,
	output parking_pkg::fee_t fee,
	output parking_pkg::floor_t current_floor,
	output parking_pkg::plate_t carried_plate,
	output parking_pkg::count_t free_sedan,
	output parking_pkg::count_t free_suv
);

	parking_pkg::request_t head;
	logic head_valid;
	logic pop;
	parking_pkg::slot_table_t slot_table;
	logic free_found;
	logic hit_found;
	parking_pkg::slot_addr_t free_addr;
	parking_pkg::slot_addr_t hit_addr;
	parking_pkg::slot_write_t slot_wr;
	parking_pkg::slot_addr_t fee_addr;
	parking_pkg::fee_t fee_value;

	request_queue i_request_queue (
		.clock(clock),
		.reset(reset),
		.push(req_valid),
		.push_req(req),
		.pop(pop),
		.head(head),
		.head_valid(head_valid),
		.full(queue_full)
	);

	slot_search i_slot_search (
		.slot_table(slot_table),
		.plate(head.plate),
		.free_found(free_found),
		.free_addr(free_addr),
		.hit_found(hit_found),
		.hit_addr(hit_addr)
	);

	slot_map i_slot_map (
		.clock(clock),
		.reset(reset),
		.slot_wr(slot_wr),
		.slot_table(slot_table),
		.free_sedan(free_sedan),
		.free_suv(free_suv)
	);

	fee_meters i_fee_meters (
		.clock(clock),
		.reset(reset),
		.slot_wr(slot_wr),
		.fee_addr(fee_addr),
		.fee_value(fee_value)
	);

	lift_controller i_lift_controller (
		.clock(clock),
		.reset(reset),
		.head(head),
		.head_valid(head_valid),
		.pop(pop),
		.free_found(free_found),
		.hit_found(hit_found),
		.free_addr(free_addr),
		.hit_addr(hit_addr),
		.slot_wr(slot_wr),
		.fee_addr(fee_addr),
		.fee_value(fee_value),
		.current_floor(current_floor),
		.carried_plate(carried_plate),
		.park_done(park_done),
		.park_addr(park_addr),
		.retrieve_done(retrieve_done),
		.fee(fee),
		.reject(reject)
	);

endmodule

// ==== verification/parking_tower_sva.sv ====
// Concurrent assertions on the parking tower outputs
// Bound into every parking_tower instance by the testbench
`timescale 1ns/1ps

module parking_tower_sva (
	input logic clock,
	input logic reset,
	input logic pop,
	input logic park_done,
	input logic retrieve_done,
	input logic reject,
	input parking_pkg::floor_t current_floor
);

	// One job at a time, so the two reports never coincide
	done_exclusive: assert property (@(posedge clock) disable iff (reset)
		!(park_done && retrieve_done))
		else $error("park_done and retrieve_done are high in the same cycle");

	// Lift moves at most one floor per cycle, with no wrap between floor 0 and the top
	floor_step: assert property (@(posedge clock) disable iff (reset)
		(current_floor == $past(current_floor))
		|| ({1'b0, current_floor} == {1'b0, $past(current_floor)} + 4'd1)
		|| ({1'b0, current_floor} + 4'd1 == {1'b0, $past(current_floor)}))
		else $error("current_floor jumped by more than one floor");

	quiet_after_reset: assert property (@(posedge clock)
		$fell(reset) |-> !(pop || park_done || retrieve_done || reject))
		else $error("pop, park_done, retrieve_done or reject active right after reset");

endmodule

// ==== verification/parking_tower_tb.sv ====
// Directed testbench for the parking tower covering allocation, overflow, fees, rejects and queueing
// Simulation top; run through build.f and the Makefile
`timescale 1ns/1ps

module parking_tower_tb;

	localparam int CLOCK_PERIOD = 10;
	// Pop, a climb to the top floor, the slot cycle and the way down
	localparam int JOB_CYCLES = 2 * parking_pkg::NUM_FLOORS + 2;
	localparam int TEST_JOBS = 39;
	// Resets, fee waits and settling gaps
	localparam int IDLE_CYCLES = 250;
	localparam int WATCHDOG_NS = 2 * (TEST_JOBS * JOB_CYCLES + IDLE_CYCLES) * CLOCK_PERIOD;

	localparam logic [1:0] EV_PARK = 2'd0;
	localparam logic [1:0] EV_RETRIEVE = 2'd1;
	localparam logic [1:0] EV_REJECT = 2'd2;
	localparam logic [3:0] STANDARD_PREFIX = 4'h2;

	typedef struct packed {
		logic [1:0] kind;
		logic [31:0] cycle;
		parking_pkg::slot_addr_t addr;
		parking_pkg::floor_t lift_floor;
		parking_pkg::fee_t fee;
		parking_pkg::plate_t plate;
	} event_t;

	logic clock;
	logic reset;
	logic req_valid;
	parking_pkg::request_t req;
	logic queue_full;
	logic park_done;
	logic retrieve_done;
	logic reject;
	parking_pkg::slot_addr_t park_addr;
	parking_pkg::fee_t fee;
	parking_pkg::floor_t current_floor;
	parking_pkg::plate_t carried_plate;
	parking_pkg::count_t free_sedan;
	parking_pkg::count_t free_suv;

	event_t events[$];
	int cycle;
	int seed;
	int serial;

	parking_tower i_parking_tower (
		.clock(clock),
		.reset(reset),
		.req_valid(req_valid),
		.req(req),
		.queue_full(queue_full),
		.park_done(park_done),
		.retrieve_done(retrieve_done),
		.reject(reject),
		.park_addr(park_addr),
		.fee(fee),
		.current_floor(current_floor),
		.carried_plate(carried_plate),
		.free_sedan(free_sedan),
		.free_suv(free_suv)
	);

	bind parking_tower parking_tower_sva i_parking_tower_sva (
		.clock(clock),
		.reset(reset),
		.pop(pop),
		.park_done(park_done),
		.retrieve_done(retrieve_done),
		.reject(reject),
		.current_floor(current_floor)
	);

	always #(CLOCK_PERIOD / 2) clock = ~clock;

	always @(posedge clock) begin
		cycle <= cycle + 1;
	end

	// Reports are logged mid-cycle with their cycle number
	always @(negedge clock) begin
		if (!reset && park_done) begin
			events.push_back({EV_PARK, 32'(cycle), park_addr, current_floor, fee,
				carried_plate});
		end
		if (!reset && retrieve_done) begin
			events.push_back({EV_RETRIEVE, 32'(cycle), park_addr, current_floor, fee,
				carried_plate});
		end
		if (!reset && reject) begin
			events.push_back({EV_REJECT, 32'(cycle), park_addr, current_floor, fee,
				carried_plate});
		end
	end

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("TB FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_equal(input string what, input int actual, input int expected);
		if (actual != expected) begin
			stop_with_failure($sformatf("FAILED at %0t ns: %s is %0d, expected %0d",
				$time, what, actual, expected));
		end
	endtask

	// Random plate with a serial number so plates stay distinct
	function automatic parking_pkg::plate_t make_plate(input logic suv, input logic [3:0] prefix);
		parking_pkg::plate_t plate;
		plate = parking_pkg::plate_t'($random(seed));
		serial = serial + 1;
		plate[8:1] = serial[7:0];
		plate[15:12] = prefix;
		plate[0] = suv;
		return plate;
	endfunction

	function automatic int rate_for(input parking_pkg::plate_t plate);
		case (plate[15:12])
			parking_pkg::DISABLED_PREFIX: return 0;
			parking_pkg::HYBRID_PREFIX: return 1;
			default: return 2;
		endcase
	endfunction

	// Fee from the park report and the pickup, which is floor cycles before retrieve_done
	function automatic int expected_fee(input int index);
		int park_cycle;
		int floor;
		int cycles;
		park_cycle = -1;
		floor = 0;
		foreach (events[i]) begin
			if (events[i].kind == EV_PARK && events[i].plate == events[index].plate) begin
				park_cycle = int'(events[i].cycle);
				floor = int'(events[i].addr.floor);
			end
		end
		cycles = int'(events[index].cycle) - floor - park_cycle;
		if (rate_for(events[index].plate) * cycles > parking_pkg::FEE_MAX) begin
			return parking_pkg::FEE_MAX;
		end
		return rate_for(events[index].plate) * cycles;
	endfunction

	task automatic apply_reset();
		@(posedge clock);
		reset <= 1'b1;
		req_valid <= 1'b0;
		repeat (5) @(posedge clock);
		reset <= 1'b0;
		events.delete();
	endtask

	task automatic send_request(
		input parking_pkg::req_kind_t kind,
		input parking_pkg::plate_t plate,
		output logic full_seen
	);
		@(posedge clock);
		req_valid <= 1'b1;
		req.kind <= kind;
		req.plate <= plate;
		@(negedge clock);
		full_seen = queue_full;
	endtask

	task automatic end_requests();
		@(posedge clock);
		req_valid <= 1'b0;
	endtask

	task automatic request_once(input parking_pkg::req_kind_t kind, input parking_pkg::plate_t plate);
		logic full;
		send_request(kind, plate, full);
		check_equal("queue_full on a single request", int'(full), 0);
		end_requests();
	endtask

	task automatic wait_events(input int count);
		int waited;
		waited = 0;
		while (events.size() < count) begin
			@(posedge clock);
			waited = waited + 1;
			if (waited > count * JOB_CYCLES) begin
				stop_with_failure("Timed out waiting for a park, retrieve or reject report");
			end
		end
	endtask

	task automatic expect_free(input int sedan, input int suv);
		@(negedge clock);
		check_equal("free_sedan", int'(free_sedan), sedan);
		check_equal("free_suv", int'(free_suv), suv);
	endtask

	task automatic check_event(input int index, input logic [1:0] kind, input parking_pkg::plate_t plate);
		check_equal($sformatf("kind of report %0d", index), int'(events[index].kind), int'(kind));
		check_equal($sformatf("plate of report %0d", index), int'(events[index].plate), int'(plate));
	endtask

	task automatic check_park(input int index, input parking_pkg::plate_t plate, input int floor,
			input int place);
		check_event(index, EV_PARK, plate);
		check_equal("park floor", int'(events[index].addr.floor), floor);
		check_equal("park place", int'(events[index].addr.place), place);
		// The lift stands at the slot's floor while it stores the car
		check_equal("current_floor at park_done", int'(events[index].lift_floor), floor);
	endtask

	task automatic test_allocation();
		parking_pkg::plate_t plates [3];
		apply_reset();
		expect_free(6, 8);
		check_equal("current_floor after reset", int'(current_floor), 0);
		check_equal("carried_plate after reset", int'(carried_plate), 0);
		plates[0] = make_plate(1'b0, STANDARD_PREFIX);
		plates[1] = make_plate(1'b0, STANDARD_PREFIX);
		plates[2] = make_plate(1'b1, STANDARD_PREFIX);
		request_once(parking_pkg::REQ_PARK, plates[0]);
		wait_events(1);
		check_park(0, plates[0], 2, 0);
		expect_free(5, 8);
		request_once(parking_pkg::REQ_PARK, plates[1]);
		wait_events(2);
		check_park(1, plates[1], 2, 1);
		expect_free(4, 8);
		request_once(parking_pkg::REQ_PARK, plates[2]);
		wait_events(3);
		check_park(2, plates[2], 1, 0);
		expect_free(4, 7);
	endtask

	task automatic test_sedan_overflow();
		parking_pkg::plate_t plates [7];
		logic full;
		apply_reset();
		for (int i = 0; i < 6; i++) begin
			plates[i] = make_plate(1'b0, STANDARD_PREFIX);
			send_request(parking_pkg::REQ_PARK, plates[i], full);
			check_equal("queue_full on a park burst", int'(full), 0);
		end
		end_requests();
		wait_events(6);
		// Even floors fill bottom up, left before right
		for (int i = 0; i < 6; i++) begin
			check_park(i, plates[i], 2 + 2 * (i / 2), i % 2);
		end
		expect_free(0, 8);
		plates[6] = make_plate(1'b0, STANDARD_PREFIX);
		request_once(parking_pkg::REQ_PARK, plates[6]);
		wait_events(7);
		check_park(6, plates[6], 1, 0);
		expect_free(0, 7);
	endtask

	task automatic test_fees();
		parking_pkg::plate_t plates [4];
		logic full;
		apply_reset();
		plates[0] = make_plate(1'b0, STANDARD_PREFIX);
		plates[1] = make_plate(1'b0, parking_pkg::HYBRID_PREFIX);
		plates[2] = make_plate(1'b1, parking_pkg::DISABLED_PREFIX);
		plates[3] = make_plate(1'b1, STANDARD_PREFIX);
		for (int i = 0; i < 4; i++) begin
			send_request(parking_pkg::REQ_PARK, plates[i], full);
			check_equal("queue_full on a park burst", int'(full), 0);
		end
		end_requests();
		wait_events(4);
		repeat (40) @(posedge clock);
		for (int i = 0; i < 3; i++) begin
			send_request(parking_pkg::REQ_RETRIEVE, plates[i], full);
			check_equal("queue_full on a retrieve burst", int'(full), 0);
		end
		end_requests();
		wait_events(7);
		// Last car stays long enough for its meter to saturate
		repeat (100) @(posedge clock);
		request_once(parking_pkg::REQ_RETRIEVE, plates[3]);
		wait_events(8);
		for (int i = 4; i < 8; i++) begin
			check_event(i, EV_RETRIEVE, plates[i - 4]);
			check_equal("retrieve fee", int'(events[i].fee), expected_fee(i));
		end
	endtask

	task automatic test_rejects();
		parking_pkg::plate_t plates [8];
		logic full;
		apply_reset();
		request_once(parking_pkg::REQ_RETRIEVE, make_plate(1'b0, STANDARD_PREFIX));
		wait_events(1);
		check_event(0, EV_REJECT, '0);
		expect_free(6, 8);
		for (int i = 0; i < 8; i++) begin
			plates[i] = make_plate(1'b1, STANDARD_PREFIX);
			send_request(parking_pkg::REQ_PARK, plates[i], full);
			check_equal("queue_full on a park burst", int'(full), 0);
		end
		end_requests();
		wait_events(9);
		for (int i = 0; i < 8; i++) begin
			check_event(i + 1, EV_PARK, plates[i]);
		end
		expect_free(6, 0);
		request_once(parking_pkg::REQ_PARK, make_plate(1'b1, STANDARD_PREFIX));
		wait_events(10);
		check_event(9, EV_REJECT, '0);
		expect_free(6, 0);
	endtask

	task automatic test_queueing();
		parking_pkg::plate_t early [3];
		parking_pkg::plate_t burst [9];
		parking_pkg::req_kind_t burst_kind [9];
		logic full_seen [9];
		logic full;
		apply_reset();
		for (int i = 0; i < 3; i++) begin
			early[i] = make_plate(1'b0, STANDARD_PREFIX);
		end
		// Mix of SUV parks, retrieves of the early sedans and one sedan park
		for (int i = 0; i < 9; i++) begin
			burst_kind[i] = parking_pkg::REQ_PARK;
			burst[i] = make_plate(i != 6, STANDARD_PREFIX);
		end
		for (int i = 0; i < 3; i++) begin
			burst_kind[2 * i + 1] = parking_pkg::REQ_RETRIEVE;
			burst[2 * i + 1] = early[i];
		end
		request_once(parking_pkg::REQ_PARK, early[0]);
		request_once(parking_pkg::REQ_PARK, early[1]);
		wait_events(2);
		repeat (JOB_CYCLES) @(posedge clock);
		// Floor 4 trip keeps the lift busy through the whole burst
		send_request(parking_pkg::REQ_PARK, early[2], full);
		check_equal("queue_full before the burst", int'(full), 0);
		for (int i = 0; i < 9; i++) begin
			send_request(burst_kind[i], burst[i], full_seen[i]);
		end
		end_requests();
		for (int i = 0; i < 9; i++) begin
			check_equal($sformatf("queue_full on burst request %0d", i), int'(full_seen[i]),
				(i == 8) ? 1 : 0);
		end
		wait_events(11);
		check_park(2, early[2], 4, 0);
		for (int i = 0; i < 8; i++) begin
			check_event(i + 3, (burst_kind[i] == parking_pkg::REQ_PARK) ? EV_PARK : EV_RETRIEVE,
				burst[i]);
		end
		repeat (JOB_CYCLES) @(posedge clock);
		check_equal("reports after the dropped request", events.size(), 11);
	endtask

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		req_valid = 1'b0;
		req = '0;
		cycle = 0;
		seed = 87;
		serial = 0;
		test_allocation();
		test_sedan_overflow();
		test_fees();
		test_rejects();
		test_queueing();
		$display("TB PASSED");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		stop_with_failure("Watchdog expired before all tests finished");
	end

endmodule

// ==== build.f ====
hdl/parking_pkg.sv
hdl/request_queue.sv
hdl/slot_search.sv
hdl/slot_map.sv
hdl/fee_meters.sv
hdl/lift_controller.sv
hdl/parking_tower.sv
verification/parking_tower_sva.sv
verification/parking_tower_tb.sv

// ==== Makefile ====
# Verilator build and run of the parking tower testbench
# Any variable can be overridden on the command line, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP ?= parking_tower_tb
FILE_LIST ?= build.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TB PASSED" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
